// ==== common/mipsCore_cfg.svh ====
`ifndef MIPSCORE_CFG_SVH
`define MIPSCORE_CFG_SVH

// word-address width of the unified memory.
`define MEM_ADDR_BITS 10

`define RESET_PC 32'h0000_0000

// byte address where the data region starts.
`define DATA_BASE 32'd2048

`endif

// ==== common/mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJal = 6'h03,
		opBeq = 6'h04,
		opAddiu = 6'h09,
		opOri = 6'h0d,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_e;

	typedef enum logic [2:0] {
		stIdle, stFetch, stDecode, stExecute, stMemory, stWriteback
	} state_e;

	// register datapath source selections.
	typedef enum logic [1:0] {port1Rs, port1Rt, port1None} port1Src_e;
	typedef enum logic [1:0] {port2Rs, port2Rt, port2None} port2Src_e;
	typedef enum logic [1:0] {wrAddrRd, wrAddrRt, wrAddrR31, wrAddrNone} wrAddrSrc_e;
	typedef enum logic [1:0] {wrDataMemory, wrDataPc, wrDataAlu} wrDataSrc_e;

	typedef struct packed {
		port1Src_e port1Src;
		port2Src_e port2Src;
		wrAddrSrc_e wrAddrSrc;
		wrDataSrc_e wrDataSrc;
		logic wrEnable;
	} regControl_t;

	typedef struct packed {
		aluOp_e op;
		logic useImm; // second operand is the immediate.
		logic zeroExt; // zero-extend instead of sign-extend.
	} aluControl_t;

	typedef struct packed {
		logic step;
		logic branch;
		logic jump;
	} pcControl_t;

	typedef struct packed {
		logic fetch;
		logic read;
		logic write;
	} memControl_t;

endpackage

// ==== mipsCore.f ====
+incdir+common
+incdir+testbench
common/mipsPkg.sv
register/regFile.sv
register/regDatapath.sv
rtl/mipsControl.sv
rtl/mipsPcCounter.sv
rtl/mipsAlu.sv
rtl/mipsMemory.sv
rtl/mipsCore.sv
testbench/mipsCoreTb.sv

// ==== register/regDatapath.sv ====
`timescale 1ns/100ps

module regDatapath (
	input logic clk,
	input logic rstN,
	input mipsPkg::regControl_t control,
	input mipsPkg::word_t pcAddr,
	input mipsPkg::word_t ramOut,
	input mipsPkg::word_t aluResult,
	input mipsPkg::word_t instruction,
	output mipsPkg::word_t port1,
	output mipsPkg::word_t port2,
	output mipsPkg::regAddr_t wrAddr,
	output mipsPkg::word_t wrData,
	output logic wrEnable
);

	mipsPkg::regAddr_t rs;
	mipsPkg::regAddr_t rt;
	mipsPkg::regAddr_t rd;
	mipsPkg::regAddr_t rd1Addr;
	mipsPkg::regAddr_t rd2Addr;

	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign wrEnable = control.wrEnable;

	always_comb begin
		case (control.port1Src)
			mipsPkg::port1Rs: rd1Addr = rs;
			mipsPkg::port1Rt: rd1Addr = rt;
			default: rd1Addr = 5'd0;
		endcase
		case (control.port2Src)
			mipsPkg::port2Rs: rd2Addr = rs;
			mipsPkg::port2Rt: rd2Addr = rt;
			default: rd2Addr = 5'd0;
		endcase
		case (control.wrAddrSrc)
			mipsPkg::wrAddrRd: wrAddr = rd;
			mipsPkg::wrAddrRt: wrAddr = rt;
			mipsPkg::wrAddrR31: wrAddr = 5'd31; // link register for jal.
			default: wrAddr = 5'd0;
		endcase
		case (control.wrDataSrc)
			mipsPkg::wrDataMemory: wrData = ramOut;
			mipsPkg::wrDataPc: wrData = pcAddr + 32'd4;
			default: wrData = aluResult;
		endcase
	end

	regFile regFile_i (
		.clk(clk),
		.rstN(rstN),
		.rd1Addr(rd1Addr),
		.rd2Addr(rd2Addr),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.wrEnable(wrEnable),
		.rd1Data(port1),
		.rd2Data(port2)
	);

endmodule

// ==== register/regFile.sv ====
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic rstN,
	input mipsPkg::regAddr_t rd1Addr,
	input mipsPkg::regAddr_t rd2Addr,
	input mipsPkg::regAddr_t wrAddr,
	input mipsPkg::word_t wrData,
	input logic wrEnable,
	output mipsPkg::word_t rd1Data,
	output mipsPkg::word_t rd2Data
);

	mipsPkg::word_t regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEnable && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData; // r0 is never written.
		end
	end

	assign rd1Data = (rd1Addr == 5'd0) ? '0 : regs[rd1Addr];
	assign rd2Data = (rd2Addr == 5'd0) ? '0 : regs[rd2Addr];

endmodule

// ==== rtl/mipsAlu.sv ====
`timescale 1ns/100ps

module mipsAlu (
	input mipsPkg::aluControl_t control,
	input mipsPkg::word_t a,
	input mipsPkg::word_t b,
	input mipsPkg::word_t instruction,
	output mipsPkg::word_t result,
	output logic zero
);

	mipsPkg::word_t imm;
	mipsPkg::word_t opB;

	always_comb begin
		if (control.zeroExt)
			imm = {16'h0000, instruction[15:0]}; // ori.
		else
			imm = {{16{instruction[15]}}, instruction[15:0]};
	end

	assign opB = control.useImm ? imm : b;

	always_comb begin
		case (control.op)
			mipsPkg::aluSub: result = a - opB;
			mipsPkg::aluAnd: result = a & opB;
			mipsPkg::aluOr: result = a | opB;
			mipsPkg::aluSlt: result = {31'd0, $signed(a) < $signed(opB)};
			default: result = a + opB;
		endcase
	end

	// beq compares through a subtraction.
	assign zero = (result == 32'd0);

endmodule

// ==== rtl/mipsControl.sv ====
`timescale 1ns/100ps

module mipsControl (
	input logic clk,
	input logic rstN,
	input logic run,
	input mipsPkg::word_t ramOut,
	input logic aluZero,
	output mipsPkg::word_t instruction,
	output mipsPkg::regControl_t regControl,
	output mipsPkg::aluControl_t aluControl,
	output mipsPkg::pcControl_t pcControl,
	output mipsPkg::memControl_t memControl,
	output logic retire
);

	mipsPkg::state_e state;
	mipsPkg::state_e nextState;
	mipsPkg::word_t ir;
	mipsPkg::opcode_e opcode;
	mipsPkg::funct_e funct;
	logic decKnown;

	function automatic logic isKnown(mipsPkg::word_t w);
		logic ok;
		case (mipsPkg::opcode_e'(w[31:26]))
			mipsPkg::opRType: begin
				case (mipsPkg::funct_e'(w[5:0]))
					mipsPkg::fnAddu, mipsPkg::fnSubu, mipsPkg::fnAnd,
					mipsPkg::fnOr, mipsPkg::fnSlt: ok = 1'b1;
					default: ok = 1'b0;
				endcase
			end
			mipsPkg::opAddiu, mipsPkg::opOri, mipsPkg::opLw,
			mipsPkg::opSw, mipsPkg::opBeq, mipsPkg::opJal: ok = 1'b1;
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	assign opcode = mipsPkg::opcode_e'(ir[31:26]);
	assign funct = mipsPkg::funct_e'(ir[5:0]);
	assign decKnown = isKnown(ramOut); // fetched word is on ramOut during decode.
	assign instruction = ir;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= mipsPkg::stIdle;
			ir <= '0;
		end else begin
			state <= nextState;
			if (state == mipsPkg::stDecode)
				ir <= ramOut;
		end
	end

	always_comb begin
		regControl.port1Src = mipsPkg::port1None;
		regControl.port2Src = mipsPkg::port2None;
		regControl.wrAddrSrc = mipsPkg::wrAddrNone;
		regControl.wrDataSrc = mipsPkg::wrDataAlu;
		regControl.wrEnable = 1'b0;
		aluControl.op = mipsPkg::aluAdd;
		aluControl.useImm = 1'b0;
		aluControl.zeroExt = 1'b0;
		pcControl = '0;
		memControl = '0;
		retire = 1'b0;

		// operand setup held steady from execute to writeback.
		if (state == mipsPkg::stExecute || state == mipsPkg::stMemory ||
			state == mipsPkg::stWriteback) begin
			case (opcode)
				mipsPkg::opRType: begin
					regControl.port1Src = mipsPkg::port1Rs;
					regControl.port2Src = mipsPkg::port2Rt;
					case (funct)
						mipsPkg::fnSubu: aluControl.op = mipsPkg::aluSub;
						mipsPkg::fnAnd: aluControl.op = mipsPkg::aluAnd;
						mipsPkg::fnOr: aluControl.op = mipsPkg::aluOr;
						mipsPkg::fnSlt: aluControl.op = mipsPkg::aluSlt;
						default: aluControl.op = mipsPkg::aluAdd;
					endcase
				end
				mipsPkg::opAddiu, mipsPkg::opLw: begin
					regControl.port1Src = mipsPkg::port1Rs;
					aluControl.useImm = 1'b1;
				end
				mipsPkg::opOri: begin
					regControl.port1Src = mipsPkg::port1Rs;
					aluControl.op = mipsPkg::aluOr;
					aluControl.useImm = 1'b1;
					aluControl.zeroExt = 1'b1;
				end
				mipsPkg::opSw: begin
					regControl.port1Src = mipsPkg::port1Rs;
					regControl.port2Src = mipsPkg::port2Rt; // store data.
					aluControl.useImm = 1'b1;
				end
				mipsPkg::opBeq: begin
					regControl.port1Src = mipsPkg::port1Rs;
					regControl.port2Src = mipsPkg::port2Rt;
					aluControl.op = mipsPkg::aluSub;
				end
				default: ;
			endcase
		end

		case (state)
			mipsPkg::stFetch: memControl.fetch = 1'b1;
			mipsPkg::stDecode: begin
				if (!decKnown) begin
					retire = 1'b1; // unknown opcode is a no-op.
					pcControl.step = 1'b1;
				end
			end
			mipsPkg::stExecute: begin
				if (opcode == mipsPkg::opBeq) begin
					retire = 1'b1;
					pcControl.branch = 1'b1;
					pcControl.step = !aluZero;
				end
			end
			mipsPkg::stMemory: begin
				if (opcode == mipsPkg::opLw) begin
					memControl.read = 1'b1;
				end else begin
					memControl.write = 1'b1;
					retire = 1'b1;
					pcControl.step = 1'b1;
				end
			end
			mipsPkg::stWriteback: begin
				retire = 1'b1;
				regControl.wrEnable = 1'b1;
				case (opcode)
					mipsPkg::opRType: regControl.wrAddrSrc = mipsPkg::wrAddrRd;
					mipsPkg::opJal: begin
						regControl.wrAddrSrc = mipsPkg::wrAddrR31;
						regControl.wrDataSrc = mipsPkg::wrDataPc;
					end
					mipsPkg::opLw: begin
						regControl.wrAddrSrc = mipsPkg::wrAddrRt;
						regControl.wrDataSrc = mipsPkg::wrDataMemory;
					end
					default: regControl.wrAddrSrc = mipsPkg::wrAddrRt;
				endcase
				pcControl.jump = (opcode == mipsPkg::opJal);
				pcControl.step = (opcode != mipsPkg::opJal);
			end
			default: ;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			mipsPkg::stIdle: nextState = run ? mipsPkg::stFetch : mipsPkg::stIdle;
			mipsPkg::stFetch: nextState = mipsPkg::stDecode;
			mipsPkg::stDecode: begin
				if (decKnown && ramOut[31:26] == mipsPkg::opJal)
					nextState = mipsPkg::stWriteback;
				else if (decKnown)
					nextState = mipsPkg::stExecute;
			end
			mipsPkg::stExecute: begin
				if (opcode == mipsPkg::opLw || opcode == mipsPkg::opSw)
					nextState = mipsPkg::stMemory;
				else if (opcode != mipsPkg::opBeq)
					nextState = mipsPkg::stWriteback;
			end
			mipsPkg::stMemory: begin
				if (opcode == mipsPkg::opLw)
					nextState = mipsPkg::stWriteback;
			end
			default: ;
		endcase
		if (retire)
			nextState = run ? mipsPkg::stFetch : mipsPkg::stIdle; // run sampled at boundary.
	end

endmodule

// ==== rtl/mipsCore.sv ====
`timescale 1ns/100ps

`include "mipsCore_cfg.svh"

module mipsCore (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic loadEn,
	input logic [`MEM_ADDR_BITS-1:0] loadAddr,
	input mipsPkg::word_t loadData,
	output logic retire,
	output mipsPkg::word_t retirePc,
	output logic wbValid,
	output mipsPkg::regAddr_t wbAddr,
	output mipsPkg::word_t wbData
);

	mipsPkg::regControl_t regControl;
	mipsPkg::aluControl_t aluControl;
	mipsPkg::pcControl_t pcControl;
	mipsPkg::memControl_t memControl;
	mipsPkg::word_t instruction;
	mipsPkg::word_t pc;
	mipsPkg::word_t ramOut;
	mipsPkg::word_t port1;
	mipsPkg::word_t port2;
	mipsPkg::word_t aluResult;
	logic aluZero;

	// pc still points at the retiring instruction.
	assign retirePc = pc;

	mipsControl mipsControl_i (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.ramOut(ramOut),
		.aluZero(aluZero),
		.instruction(instruction),
		.regControl(regControl),
		.aluControl(aluControl),
		.pcControl(pcControl),
		.memControl(memControl),
		.retire(retire)
	);

	mipsPcCounter mipsPcCounter_i (
		.clk(clk),
		.rstN(rstN),
		.pcControl(pcControl),
		.instruction(instruction),
		.aluZero(aluZero),
		.pc(pc)
	);

	regDatapath regDatapath_i (
		.clk(clk),
		.rstN(rstN),
		.control(regControl),
		.pcAddr(pc),
		.ramOut(ramOut),
		.aluResult(aluResult),
		.instruction(instruction),
		.port1(port1),
		.port2(port2),
		.wrAddr(wbAddr),
		.wrData(wbData),
		.wrEnable(wbValid)
	);

	mipsAlu mipsAlu_i (
		.control(aluControl),
		.a(port1),
		.b(port2),
		.instruction(instruction),
		.result(aluResult),
		.zero(aluZero)
	);

	mipsMemory mipsMemory_i (
		.clk(clk),
		.memControl(memControl),
		.pc(pc),
		.addr(aluResult),
		.wrData(port2),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.rdData(ramOut)
	);

endmodule

// ==== rtl/mipsMemory.sv ====
`timescale 1ns/100ps

`include "mipsCore_cfg.svh"

module mipsMemory (
	input logic clk,
	input mipsPkg::memControl_t memControl,
	input mipsPkg::word_t pc,
	input mipsPkg::word_t addr,
	input mipsPkg::word_t wrData,
	input logic loadEn,
	input logic [`MEM_ADDR_BITS-1:0] loadAddr,
	input mipsPkg::word_t loadData,
	output mipsPkg::word_t rdData
);

	localparam int Depth = 1 << `MEM_ADDR_BITS;

	mipsPkg::word_t mem [Depth];
	logic [`MEM_ADDR_BITS-1:0] dataIndex;
	logic [`MEM_ADDR_BITS-1:0] rdIndex;

	assign dataIndex = addr[`MEM_ADDR_BITS+1:2]; // byte to word address.
	assign rdIndex = memControl.fetch ? pc[`MEM_ADDR_BITS+1:2] : dataIndex;

	always_ff @(posedge clk) begin
		if (memControl.write)
			mem[dataIndex] <= wrData;
		else if (loadEn)
			mem[loadAddr] <= loadData; // load port only used while the core idles.
		if (memControl.fetch || memControl.read)
			rdData <= mem[rdIndex];
	end

endmodule

// ==== rtl/mipsPcCounter.sv ====
`timescale 1ns/100ps

`include "mipsCore_cfg.svh"

module mipsPcCounter (
	input logic clk,
	input logic rstN,
	input mipsPkg::pcControl_t pcControl,
	input mipsPkg::word_t instruction,
	input logic aluZero,
	output mipsPkg::word_t pc
);

	mipsPkg::word_t pcPlus4;
	mipsPkg::word_t branchTarget;
	mipsPkg::word_t jumpTarget;

	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instruction[25:0], 2'b00}; // stays in the 256 MB region.

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= `RESET_PC;
		else if (pcControl.jump)
			pc <= jumpTarget;
		else if (pcControl.branch && aluZero)
			pc <= branchTarget;
		else if (pcControl.step)
			pc <= pcPlus4;
	end

endmodule

// ==== run.sh ====
#!/bin/bash
# builds the testbench with Verilator and runs it; the exit status is 0 only on a pass.
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module mipsCoreTb -f mipsCore.f || exit 1
simOut="$(./obj_dir/VmipsCoreTb 2>&1)"
echo "$simOut"
echo "$simOut" | grep -qxF ">>> PASS" && echo "run.sh: simulation passed" || { echo "run.sh: simulation failed"; exit 1; }

// ==== testbench/mipsModel.svh ====
`ifndef MIPSMODEL_SVH
`define MIPSMODEL_SVH

// one retirement as the model expects it.
typedef struct packed {
	logic [31:0] pc;
	logic wb;
	logic [4:0] addr;
	logic [31:0] data;
} retireRec_t;

mipsPkg::word_t modelMem [1 << `MEM_ADDR_BITS];
mipsPkg::word_t modelRegs [32];
retireRec_t expectQ [$];

// executes the instruction at pc and returns the next pc.
function automatic mipsPkg::word_t modelStep(mipsPkg::word_t pc);
	mipsPkg::word_t ins;
	mipsPkg::word_t a;
	mipsPkg::word_t b;
	mipsPkg::word_t imm;
	mipsPkg::word_t ea;
	mipsPkg::word_t next;
	retireRec_t rec;
	ins = modelMem[pc[`MEM_ADDR_BITS+1:2]];
	a = modelRegs[ins[25:21]];
	b = modelRegs[ins[20:16]];
	imm = {{16{ins[15]}}, ins[15:0]};
	ea = a + imm;
	next = pc + 32'd4;
	rec.pc = pc;
	rec.wb = 1'b1;
	rec.addr = ins[20:16];
	rec.data = '0;
	case (ins[31:26])
		mipsPkg::opRType: begin
			rec.addr = ins[15:11];
			case (ins[5:0])
				mipsPkg::fnAddu: rec.data = a + b;
				mipsPkg::fnSubu: rec.data = a - b;
				mipsPkg::fnAnd: rec.data = a & b;
				mipsPkg::fnOr: rec.data = a | b;
				mipsPkg::fnSlt: rec.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default: rec.wb = 1'b0;
			endcase
		end
		mipsPkg::opAddiu: rec.data = ea;
		mipsPkg::opOri: rec.data = a | {16'h0000, ins[15:0]};
		mipsPkg::opLw: rec.data = modelMem[ea[`MEM_ADDR_BITS+1:2]];
		mipsPkg::opSw: begin
			rec.wb = 1'b0;
			modelMem[ea[`MEM_ADDR_BITS+1:2]] = b;
		end
		mipsPkg::opBeq: begin
			rec.wb = 1'b0;
			if (a == b)
				next = next + {imm[29:0], 2'b00};
		end
		mipsPkg::opJal: begin
			rec.addr = 5'd31;
			rec.data = next; // link is pc+4.
			next = {next[31:28], ins[25:0], 2'b00};
		end
		default: rec.wb = 1'b0; // unknown opcode is a no-op.
	endcase
	if (rec.wb && rec.addr != 5'd0)
		modelRegs[rec.addr] = rec.data;
	expectQ.push_back(rec);
	return next;
endfunction

// runs from reset up to and including the first pass through EndPc.
task automatic modelRun();
	mipsPkg::word_t pc;
	logic atEnd;
	int steps;
	int r;
	for (r = 0; r < 32; r++)
		modelRegs[r] = '0;
	pc = `RESET_PC;
	atEnd = 1'b0;
	steps = 0;
	while (!atEnd && steps < 200) begin
		atEnd = (pc == EndPc);
		pc = modelStep(pc);
		steps++;
	end
endtask

`endif

// ==== testbench/mipsCoreTb.sv ====
`timescale 1ns/100ps

`include "mipsCore_cfg.svh"

module mipsCoreTb;

	localparam int ProgLen = 64;
	localparam int DataLen = 16;
	localparam int DataBaseWord = `DATA_BASE / 4;
	localparam logic [31:0] EndPc = 32'(ProgLen * 4);
	// reset, loading and 70 instructions of at most 6 cycles.
	localparam int TimeoutCycles = 8 + ProgLen + 1 + DataLen + 8 + 70 * 6;

	typedef logic [`MEM_ADDR_BITS-1:0] memAddr_t;

	logic clk;
	logic rstN;
	logic run;
	logic loadEn;
	memAddr_t loadAddr;
	mipsPkg::word_t loadData;
	logic retire;
	mipsPkg::word_t retirePc;
	logic wbValid;
	mipsPkg::regAddr_t wbAddr;
	mipsPkg::word_t wbData;

	logic running;
	logic done;
	int retireCount;
	mipsPkg::word_t progWords [ProgLen + 1];
	mipsPkg::word_t dataWords [DataLen];

	`include "mipsModel.svh"

	mipsCore mipsCore_i (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.retire(retire),
		.retirePc(retirePc),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	always #5 clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal)
			abortRun($sformatf("Error: %s expected %h actual %h", name, expVal, actVal));
	endtask

	function automatic mipsPkg::regAddr_t pickReg();
		return 5'($urandom_range(7, 0)); // few registers, so values get reused.
	endfunction

	function automatic mipsPkg::funct_e pickFunct();
		mipsPkg::funct_e f;
		case ($urandom_range(4, 0))
			0: f = mipsPkg::fnAddu;
			1: f = mipsPkg::fnSubu;
			2: f = mipsPkg::fnAnd;
			3: f = mipsPkg::fnOr;
			default: f = mipsPkg::fnSlt;
		endcase
		return f;
	endfunction

	function automatic logic [15:0] dataOffset();
		logic [31:0] off;
		off = `DATA_BASE + 4 * $urandom_range(DataLen - 1, 0);
		return off[15:0];
	endfunction

	function automatic mipsPkg::word_t genInstr(int idx);
		int kind;
		int maxFwd;
		mipsPkg::regAddr_t rs;
		mipsPkg::regAddr_t rt;
		mipsPkg::regAddr_t rd;
		logic [31:0] target;
		mipsPkg::word_t ins;
		kind = (idx < 4) ? $urandom_range(29, 0) : $urandom_range(99, 0);
		rs = pickReg();
		rt = pickReg();
		rd = pickReg();
		maxFwd = (ProgLen - 1 - idx > 3) ? 3 : ProgLen - 1 - idx; // stay inside the program.
		if (kind < 20)
			ins = {mipsPkg::opAddiu, rs, rt, 16'($urandom)};
		else if (kind < 30)
			ins = {mipsPkg::opOri, rs, rt, 16'($urandom)};
		else if (kind < 65)
			ins = {mipsPkg::opRType, rs, rt, rd, 5'd0, pickFunct()};
		else if (kind < 75)
			ins = {mipsPkg::opLw, 5'd0, rt, dataOffset()};
		else if (kind < 85)
			ins = {mipsPkg::opSw, 5'd0, rt, dataOffset()};
		else if (kind < 93) begin
			if ($urandom_range(1, 0) == 1)
				rt = rs; // makes taken branches common.
			ins = {mipsPkg::opBeq, rs, rt, 16'($urandom_range(maxFwd, 0))};
		end else begin
			target = 32'((idx + 1 + int'($urandom_range(maxFwd, 0))) * 4);
			ins = {mipsPkg::opJal, target[27:2]};
		end
		return ins;
	endfunction

	task automatic buildImage();
		int i;
		for (i = 0; i < ProgLen; i++)
			progWords[i] = genInstr(i);
		progWords[ProgLen] = {mipsPkg::opBeq, 5'd0, 5'd0, 16'hffff}; // branch to itself.
		for (i = 0; i < DataLen; i++)
			dataWords[i] = $urandom;
		for (i = 0; i <= ProgLen; i++)
			modelMem[i] = progWords[i];
		for (i = 0; i < DataLen; i++)
			modelMem[DataBaseWord + i] = dataWords[i];
	endtask

	task automatic loadWord(input memAddr_t addr, input mipsPkg::word_t data);
		@(negedge clk);
		loadEn <= 1'b1;
		loadAddr <= addr;
		loadData <= data;
	endtask

	task automatic loadImage();
		int i;
		for (i = 0; i <= ProgLen; i++)
			loadWord(memAddr_t'(i), progWords[i]);
		for (i = 0; i < DataLen; i++)
			loadWord(memAddr_t'(DataBaseWord + i), dataWords[i]);
		@(negedge clk);
		loadEn <= 1'b0;
	endtask

	// retire and writeback monitor.
	always @(negedge clk) begin
		retireRec_t rec;
		if (!running) begin
			checkValue("retire while idle", 32'd0, 32'(retire));
			checkValue("wbValid while idle", 32'd0, 32'(wbValid));
		end else if (retire && !done) begin
			if (expectQ.size() == 0) begin
				abortRun("the core retired more instructions than the model");
			end else begin
				rec = expectQ.pop_front();
				if (retireCount == 0)
					checkValue("first retire pc", `RESET_PC, retirePc);
				checkValue($sformatf("retire pc #%0d", retireCount), rec.pc, retirePc);
				checkValue($sformatf("wbValid at pc %h", rec.pc), 32'(rec.wb), 32'(wbValid));
				if (rec.wb) begin
					checkValue($sformatf("wbAddr at pc %h", rec.pc), 32'(rec.addr), 32'(wbAddr));
					checkValue($sformatf("wbData at pc %h", rec.pc), rec.data, wbData);
				end
				retireCount <= retireCount + 1;
				if (rec.pc == EndPc)
					done <= 1'b1;
			end
		end else if (!retire) begin
			checkValue("wbValid without retire", 32'd0, 32'(wbValid));
		end
	end

	initial begin
		repeat (TimeoutCycles) @(posedge clk);
		abortRun($sformatf("watchdog: the program did not end within %0d cycles",
			TimeoutCycles));
	end

	initial begin
		void'($urandom(32'h9a4df7b7));
		clk = 1'b0;
		rstN <= 1'b0;
		run <= 1'b0;
		loadEn <= 1'b0;
		loadAddr <= '0;
		loadData <= '0;
		running <= 1'b0;
		done <= 1'b0;
		retireCount <= 0;
		buildImage();
		modelRun();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN <= 1'b1;
		loadImage();
		@(negedge clk);
		run <= 1'b1;
		running <= 1'b1;
		wait (done);
		$display(">>> PASS");
		$finish;
	end

endmodule
